//--- files.f
verilog/wasm_isa_pkg.sv
verilog/wasm_machine_pkg.sv
verilog/code_mem.sv
verilog/operand_stack.sv
verilog/leb128_decoder.sv
verilog/wasm_cpu.sv
bench/wasm_cpu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module wasm_cpu_tb -o wasm_cpu_sim \
  && ./obj_dir/wasm_cpu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

//--- bench/wasm_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wasm_cpu_tb;

  import wasm_isa_pkg::*;
  import wasm_machine_pkg::*;

  localparam int n_const = 6;
  localparam int n_arith = 8;
  localparam int n_select = 6;
  localparam int num_tests = n_const + n_arith + n_select + 6;
  // Load, reset release, then up to 64 instructions of 6 cycles each
  localparam int test_cycles = 64 + 2 + 64 * 6 + 8;
  localparam int watchdog_ns = num_tests * test_cycles * 10 + 1000;

  logic        clk = 1'b0;
  logic        reset;
  logic [5:0]  start_pc;
  logic        write;
  logic [5:0]  write_addr;
  logic [7:0]  write_data;
  logic [63:0] result;
  val_type_t   result_type;
  logic        result_empty;
  trap_t       trap;

  logic [31:0] lfsr = 32'h6b10;
  logic [7:0]  prog [64];
  int          pos;
  int          test_count = 0;
  int          checks = 0;
  int          errors = 0;

  // Reference interpreter state
  logic [1:0]  m_tag [stack_depth];
  logic [63:0] m_val [stack_depth];
  int          m_sp;
  trap_t       exp_trap;
  logic [63:0] exp_result;
  logic [1:0]  exp_type;
  logic        exp_empty;

  wasm_cpu #(
    .addr_width(6)
  ) dut_i (
    .clk(clk),
    .reset(reset),
    .start_pc(start_pc),
    .write(write),
    .write_addr(write_addr),
    .write_data(write_data),
    .result(result),
    .result_type(result_type),
    .result_empty(result_empty),
    .trap(trap)
  );

  always #5 clk = ~clk;

  // One LFSR step per bit taken
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task clear_prog();
    for (int a = 0; a < 64; a++) begin
      prog[a] = 8'h00;
    end
    pos = 0;
  endtask

  task emit(input logic [7:0] b);
    prog[pos] = b;
    pos++;
  endtask

  task emit_small_i32(input logic force_zero);
    emit(op_i32_const);
    emit(force_zero ? 8'h00 : {1'b0, 7'(lfsr_bits(7))});
  endtask

  // Integer consts get a random encoding length from minimal up to ten bytes
  task emit_const(input logic [1:0] kind);
    logic [63:0]        v;
    logic signed [63:0] sv;
    int                 n;
    v = lfsr_bits(64);
    if (kind == val_f32 || kind == val_f64) begin
      emit(kind == val_f32 ? op_f32_const : op_f64_const);
      for (int i = 0; i < ((kind == val_f32) ? 4 : 8); i++) begin
        emit(v[8*i +: 8]);
      end
    end else begin
      sv = $signed(v) >>> lfsr_bits(6);
      if (kind == val_i32) begin
        sv = {{32{sv[31]}}, sv[31:0]};
      end
      n = 1;
      while (n < 10 && (sv >>> (7 * n - 1)) != 0 && (sv >>> (7 * n - 1)) != -1) begin
        n++;
      end
      n = n + int'(lfsr_bits(4) % 64'(11 - n));
      emit(kind == val_i32 ? op_i32_const : op_i64_const);
      for (int i = 0; i < n; i++) begin
        emit({i < n - 1, 7'(sv >>> (7 * i))});
      end
    end
  endtask

  task gen_consts();
    int count;
    count = 1 + int'(lfsr_bits(2));
    for (int i = 0; i < count; i++) begin
      emit_const(2'(lfsr_bits(2)));
    end
    emit(op_end);
  endtask

  // Tracks operand types so that every op stays well typed
  task gen_arith();
    logic [1:0] gt [8];
    int         gsp;
    logic [2:0] r;
    logic [1:0] k;
    logic [1:0] t;
    gsp = 0;
    while (pos < 38) begin
      r = 3'(lfsr_bits(3));
      if (gsp == 0 || (r < 3 && gsp < 6)) begin
        t = 2'(lfsr_bits(1));
        emit_const(t);
        gt[gsp] = t;
        gsp++;
      end else if (r < 6 && gsp >= 2 && gt[gsp-1] == gt[gsp-2]) begin
        k = 2'(lfsr_bits(2));
        t = gt[gsp-1];
        case (k)
          2'd0: emit(t == val_i32 ? op_i32_add : op_i64_add);
          2'd1: emit(t == val_i32 ? op_i32_sub : op_i64_sub);
          2'd2: emit(t == val_i32 ? op_i32_eq : op_i64_eq);
          default: emit(t == val_i32 ? op_i32_ne : op_i64_ne);
        endcase
        gsp--;
        gt[gsp-1] = k[1] ? 2'(val_i32) : t;
      end else if (r == 6) begin
        emit(gt[gsp-1] == val_i32 ? op_i32_eqz : op_i64_eqz);
        gt[gsp-1] = val_i32;
      end else if (r == 7) begin
        emit(op_drop);
        gsp--;
      end else begin
        emit(op_nop);
      end
    end
    emit(op_end);
  endtask

  // Jumps over a few unreachable bytes, then a select or a reinterpret
  task gen_select();
    logic [1:0] kind;
    int         target;
    target = 3 + int'(lfsr_bits(2));
    emit(op_call);
    emit(8'(target));
    pos = target;
    if (lfsr_bits(1) != 0) begin
      kind = 2'(lfsr_bits(2));
      emit_const(kind);
      emit_const(lfsr_bits(2) != 0 ? kind : 2'(lfsr_bits(2)));
      emit_small_i32(lfsr_bits(1) != 0);
      emit(op_select);
    end else begin
      emit_const(lfsr_bits(2) != 0 ? 2'(val_f32) : 2'(lfsr_bits(2)));
      emit(op_i32_reinterpret_f32);
    end
    emit(op_end);
  endtask

  task decode_leb(input int at, output logic [63:0] value, output int len);
    logic [7:0] b;
    value = '0;
    len = 0;
    do begin
      b = prog[(at + len) % 64];
      value = value | (64'(b[6:0]) << (7 * len));
      len++;
    end while (b[7] && len < 10);
    if (b[6] && len < 10) begin
      value = value | (~64'b0 << (7 * len));
    end
  endtask

  task model_push(input logic [1:0] tag, input logic [63:0] value);
    if (m_sp == stack_depth) begin
      exp_trap = trap_stack;
    end else begin
      m_tag[m_sp] = tag;
      m_val[m_sp] = value;
      m_sp++;
    end
  endtask

  task run_model(input int start);
    logic [63:0] v;
    logic [63:0] raw;
    logic [63:0] r;
    logic [7:0]  op;
    logic [1:0]  want;
    logic        is64;
    int          pc;
    int          len;
    m_sp = 0;
    pc = start;
    exp_trap = trap_none;
    exp_result = '0;
    exp_type = val_i32;
    exp_empty = 1'b1;
    while (exp_trap == trap_none) begin
      if (pc + 10 > 63) begin
        exp_trap = trap_fetch;
      end else begin
        op = prog[pc];
        pc = (pc + 1) % 64;
        decode_leb(pc, v, len);
        raw = '0;
        for (int i = 7; i >= 0; i--) begin
          raw = {raw[55:0], prog[(pc + i) % 64]};
        end
        is64 = op inside {op_i64_eq, op_i64_ne, op_i64_add, op_i64_sub};
        want = is64 ? val_i64 : val_i32;
        case (op)
          op_unreachable: exp_trap = trap_unreachable;
          op_nop: begin
          end
          op_end: begin
            exp_empty = (m_sp == 0);
            exp_result = (m_sp == 0) ? 64'b0 : m_val[m_sp-1];
            exp_type = (m_sp == 0) ? 2'b0 : m_tag[m_sp-1];
          end
          op_call: pc = int'(v[5:0]);
          op_i32_const: begin
            model_push(val_i32, {32'b0, v[31:0]});
            pc = (pc + len) % 64;
          end
          op_i64_const: begin
            model_push(val_i64, v);
            pc = (pc + len) % 64;
          end
          op_f32_const: begin
            model_push(val_f32, {32'b0, raw[31:0]});
            pc = (pc + 4) % 64;
          end
          op_f64_const: begin
            model_push(val_f64, raw);
            pc = (pc + 8) % 64;
          end
          op_drop: begin
            if (m_sp == 0) begin
              exp_trap = trap_stack;
            end else begin
              m_sp--;
            end
          end
          op_i32_eqz, op_i64_eqz: begin
            if (m_sp == 0) begin
              exp_trap = trap_stack;
            end else if (m_tag[m_sp-1] != ((op == op_i32_eqz) ? val_i32 : val_i64)) begin
              exp_trap = trap_type;
            end else begin
              m_val[m_sp-1] = {63'b0, m_val[m_sp-1] == 64'b0};
              m_tag[m_sp-1] = val_i32;
            end
          end
          op_i32_reinterpret_f32: begin
            if (m_sp == 0) begin
              exp_trap = trap_stack;
            end else if (m_tag[m_sp-1] != val_f32) begin
              exp_trap = trap_type;
            end else begin
              m_tag[m_sp-1] = val_i32;
              m_val[m_sp-1] = {32'b0, m_val[m_sp-1][31:0]};
            end
          end
          // Condition on top, upper operand below it, deeper operand below that
          op_select: begin
            if (m_sp == 0) begin
              exp_trap = trap_stack;
            end else if (m_tag[m_sp-1] != val_i32) begin
              exp_trap = trap_type;
            end else if (m_sp < 3) begin
              exp_trap = trap_stack;
            end else if (m_tag[m_sp-2] != m_tag[m_sp-3]) begin
              exp_trap = trap_select_types;
            end else begin
              if (m_val[m_sp-1][31:0] == 32'b0) begin
                m_val[m_sp-3] = m_val[m_sp-2];
              end
              m_sp = m_sp - 2;
            end
          end
          op_i32_eq, op_i32_ne, op_i32_add, op_i32_sub,
          op_i64_eq, op_i64_ne, op_i64_add, op_i64_sub: begin
            if (m_sp < 2) begin
              exp_trap = trap_stack;
            end else if (m_tag[m_sp-1] != want || m_tag[m_sp-2] != want) begin
              exp_trap = trap_type;
            end else begin
              case (op)
                op_i32_eq, op_i64_eq: r = {63'b0, m_val[m_sp-2] == m_val[m_sp-1]};
                op_i32_ne, op_i64_ne: r = {63'b0, m_val[m_sp-2] != m_val[m_sp-1]};
                op_i32_add, op_i64_add: r = m_val[m_sp-2] + m_val[m_sp-1];
                default: r = m_val[m_sp-2] - m_val[m_sp-1];
              endcase
              if (!is64) begin
                r[63:32] = '0;
              end
              m_sp--;
              m_val[m_sp-1] = r;
              m_tag[m_sp-1] = (op inside {op_i32_eq, op_i32_ne, op_i64_eq, op_i64_ne}) ?
                2'(val_i32) : want;
            end
          end
          default: exp_trap = trap_unknown;
        endcase
      end
    end
  endtask

  task check_value(input string what, input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  // Program is loaded while the CPU is held in reset
  task run_test(input int start, input string name);
    string label;
    for (int a = 0; a < 64; a++) begin
      @(posedge clk);
      reset <= 1'b1;
      write <= 1'b1;
      write_addr <= 6'(a);
      write_data <= prog[a];
    end
    @(posedge clk);
    write <= 1'b0;
    start_pc <= 6'(start);
    @(posedge clk);
    reset <= 1'b0;
    run_model(start);
    do begin
      @(negedge clk);
    end while (trap == trap_none);
    test_count++;
    label = $sformatf("%s %0d", name, test_count);
    check_value({label, " trap"}, 64'(exp_trap), 64'(trap));
    check_value({label, " result"}, exp_result, result);
    check_value({label, " result_type"}, 64'(exp_type), 64'(result_type));
    check_value({label, " result_empty"}, 64'(exp_empty), 64'(result_empty));
  endtask

  initial begin
    reset = 1'b1;
    start_pc = '0;
    write = 1'b0;
    write_addr = '0;
    write_data = '0;
    repeat (3) @(posedge clk);
    for (int t = 0; t < n_const; t++) begin
      clear_prog();
      gen_consts();
      run_test(0, "consts");
    end
    for (int t = 0; t < n_arith; t++) begin
      clear_prog();
      gen_arith();
      run_test(0, "arith");
    end
    for (int t = 0; t < n_select; t++) begin
      clear_prog();
      gen_select();
      run_test(0, "select");
    end
    clear_prog();
    emit_const(val_i32);
    emit(op_end);
    emit_const(val_i64);
    emit(op_i32_add);
    run_test(0, "mixed types");
    clear_prog();
    emit_const(val_i32);
    emit(op_end);
    emit(8'hff);
    run_test(0, "unknown opcode");
    // Nine pushes on an eight-entry stack
    clear_prog();
    emit_small_i32(1'b0);
    emit(op_end);
    repeat (8) emit_small_i32(1'b0);
    run_test(0, "overflow");
    clear_prog();
    emit_const(val_i32);
    emit(op_end);
    emit(op_drop);
    emit(op_drop);
    run_test(0, "underflow");
    clear_prog();
    emit(op_end);
    run_test(54 + int'(lfsr_bits(3)), "fetch bound");
    // Second end sees the stack empty again after a non-empty end
    clear_prog();
    emit_const(val_f64);
    emit(op_end);
    emit(op_drop);
    emit(op_end);
    run_test(0, "empty end");
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the CPU did not trap within %0d ns", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/wasm_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module wasm_cpu #(
  parameter int addr_width = 6
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [addr_width-1:0]    start_pc,
  input  logic                     write,
  input  logic [addr_width-1:0]    write_addr,
  input  byte                      write_data,
  output logic [63:0]              result,
  output wasm_isa_pkg::val_type_t  result_type,
  output logic                     result_empty,
  output wasm_machine_pkg::trap_t  trap
);

  import wasm_isa_pkg::*;
  import wasm_machine_pkg::*;

  typedef enum logic [2:0] {
    st_fetch,
    st_wait,
    st_exec,
    st_exec2,
    st_exec3,
    st_exec4
  } state_t;

  state_t                        step;
  logic [addr_width-1:0]         pc;
  logic [addr_width-1:0]         fetch_addr;
  logic [7:0]                    opcode;
  logic [window_bytes*8-1:0]     window;
  logic                          fetch_error;
  stack_op_t                     stack_op;
  logic [entry_width-1:0]        stack_data;
  logic [entry_width-1:0]        stack_tos;
  stack_status_t                 stack_status;
  logic [63:0]                   leb_value;
  logic [leb_len_width-1:0]      leb_length;
  logic [63:0]                   raw_le;
  logic                          needs_operand;
  logic [1:0]                    tos_tag;
  // Top operand popped first, then the select operand above the deeper one
  logic [entry_width-1:0]        aux1;
  logic [entry_width-1:0]        aux2;

  code_mem #(
    .addr_width(addr_width)
  ) code_mem_i (
    .clk(clk),
    .write(write),
    .write_addr(write_addr),
    .write_data(write_data),
    .fetch_addr(fetch_addr),
    .window(window),
    .fetch_error(fetch_error)
  );

  operand_stack operand_stack_i (
    .clk(clk),
    .reset(reset),
    .op(stack_op),
    .data(stack_data),
    .tos(stack_tos),
    .status(stack_status)
  );

  leb128_decoder leb128_decoder_i (
    .bytes(window[leb_max_bytes*8-1:0]),
    .value(leb_value),
    .length(leb_length)
  );

  assign tos_tag = stack_tos[65:64];

  // Float immediates are raw little-endian bytes
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      raw_le[8*i +: 8] = window[8*(window_bytes-2-i) +: 8];
    end
  end

  always_comb begin
    case (window[87:80])
      op_drop, op_select, op_i32_eqz, op_i64_eqz, op_i32_eq, op_i32_ne,
      op_i64_eq, op_i64_ne, op_i32_add, op_i32_sub, op_i64_add, op_i64_sub,
      op_i32_reinterpret_f32: needs_operand = 1'b1;
      default: needs_operand = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      trap         <= trap_none;
      step         <= st_fetch;
      pc           <= start_pc;
      stack_op     <= stack_none;
      result       <= '0;
      result_type  <= val_i32;
      result_empty <= 1'b1;
    end else begin
      stack_op <= stack_none;
      if (trap == trap_none) begin
        case (step)
          st_fetch: begin
            fetch_addr <= pc;
            pc         <= pc + 1'b1;
            step       <= st_wait;
          end

          // Previous instruction's stack op has landed by now
          st_wait: begin
            if (stack_status == status_overflow || stack_status == status_underflow) begin
              trap <= trap_stack;
            end else begin
              step <= st_exec;
            end
          end

          st_exec: begin
            opcode <= window[87:80];
            step   <= st_fetch;
            if (fetch_error) begin
              trap <= trap_fetch;
            end else if (needs_operand && stack_status == status_empty) begin
              trap <= trap_stack;
            end else begin
              case (window[87:80])
                op_unreachable: trap <= trap_unreachable;
                op_nop: begin
                end
                op_end: begin
                  result       <= stack_tos[63:0];
                  result_type  <= val_type_t'(tos_tag);
                  result_empty <= (stack_status == status_empty);
                end
                op_call: begin
                  aux1 <= {val_i64, leb_value};
                  step <= st_exec2;
                end
                op_drop: stack_op <= stack_pop;
                op_i32_const: begin
                  stack_op   <= stack_push;
                  stack_data <= {val_i32, 32'b0, leb_value[31:0]};
                  pc         <= pc + addr_width'(leb_length);
                end
                op_i64_const: begin
                  stack_op   <= stack_push;
                  stack_data <= {val_i64, leb_value};
                  pc         <= pc + addr_width'(leb_length);
                end
                op_f32_const: begin
                  stack_op   <= stack_push;
                  stack_data <= {val_f32, 32'b0, raw_le[31:0]};
                  pc         <= pc + addr_width'(4);
                end
                op_f64_const: begin
                  stack_op   <= stack_push;
                  stack_data <= {val_f64, raw_le};
                  pc         <= pc + addr_width'(8);
                end
                op_i32_eqz, op_i64_eqz: begin
                  if (tos_tag != ((window[87:80] == op_i32_eqz) ? val_i32 : val_i64)) begin
                    trap <= trap_type;
                  end else begin
                    stack_op   <= stack_replace;
                    stack_data <= {val_i32, 63'b0, stack_tos[63:0] == 64'b0};
                  end
                end
                op_i32_reinterpret_f32: begin
                  if (tos_tag != val_f32) begin
                    trap <= trap_type;
                  end else begin
                    stack_op   <= stack_replace;
                    stack_data <= {val_i32, 32'b0, stack_tos[31:0]};
                  end
                end
                op_select: begin
                  // Condition must be an i32 before anything is popped
                  if (tos_tag != val_i32) begin
                    trap <= trap_type;
                  end else begin
                    aux1     <= stack_tos;
                    stack_op <= stack_pop;
                    step     <= st_exec2;
                  end
                end
                op_i32_eq, op_i32_ne, op_i64_eq, op_i64_ne,
                op_i32_add, op_i32_sub, op_i64_add, op_i64_sub: begin
                  aux1     <= stack_tos;
                  stack_op <= stack_pop;
                  step     <= st_exec2;
                end
                default: trap <= trap_unknown;
              endcase
            end
          end

          st_exec2: begin
            step <= st_exec3;
            // Second pop for select takes the upper operand off
            if (opcode == op_select) begin
              stack_op <= stack_pop;
            end
          end

          st_exec3: begin
            step <= st_fetch;
            if (opcode != op_call && stack_status != status_ok) begin
              trap <= trap_stack;
            end else begin
              case (opcode)
                op_call: pc <= aux1[addr_width-1:0];
                op_select: begin
                  aux2 <= stack_tos;
                  step <= st_exec4;
                end
                op_i32_eq, op_i32_ne, op_i32_add, op_i32_sub: begin
                  if (aux1[65:64] != val_i32 || tos_tag != val_i32) begin
                    trap <= trap_type;
                  end else begin
                    stack_op <= stack_replace;
                    case (opcode)
                      op_i32_eq: stack_data <= {val_i32, 63'b0, stack_tos[31:0] == aux1[31:0]};
                      op_i32_ne: stack_data <= {val_i32, 63'b0, stack_tos[31:0] != aux1[31:0]};
                      op_i32_add: stack_data <= {val_i32, 32'b0, stack_tos[31:0] + aux1[31:0]};
                      default: stack_data <= {val_i32, 32'b0, stack_tos[31:0] - aux1[31:0]};
                    endcase
                  end
                end
                op_i64_eq, op_i64_ne, op_i64_add, op_i64_sub: begin
                  if (aux1[65:64] != val_i64 || tos_tag != val_i64) begin
                    trap <= trap_type;
                  end else begin
                    stack_op <= stack_replace;
                    case (opcode)
                      op_i64_eq: stack_data <= {val_i32, 63'b0, stack_tos[63:0] == aux1[63:0]};
                      op_i64_ne: stack_data <= {val_i32, 63'b0, stack_tos[63:0] != aux1[63:0]};
                      op_i64_add: stack_data <= {val_i64, stack_tos[63:0] + aux1[63:0]};
                      default: stack_data <= {val_i64, stack_tos[63:0] - aux1[63:0]};
                    endcase
                  end
                end
                default: begin
                end
              endcase
            end
          end

          // Deeper select operand is now on top of the stack
          st_exec4: begin
            step <= st_fetch;
            if (stack_status != status_ok) begin
              trap <= trap_stack;
            end else if (aux2[65:64] != tos_tag) begin
              trap <= trap_select_types;
            end else if (aux1[31:0] == 32'b0) begin
              stack_op   <= stack_replace;
              stack_data <= aux2;
            end
          end

          default: step <= st_fetch;
        endcase
      end
    end
  end

  trap_sticky: assert property (
    @(posedge clk) disable iff (reset) (trap != trap_none) |=> $stable(trap)
  );

endmodule

`default_nettype wire

//--- verilog/leb128_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module leb128_decoder (
  input  logic [wasm_isa_pkg::leb_max_bytes*8-1:0] bytes,
  output logic [63:0]                             value,
  output logic [wasm_isa_pkg::leb_len_width-1:0]  length
);

  import wasm_isa_pkg::*;

  localparam int group_total = leb_group_bits * leb_max_bytes;

  logic [group_total-1:0]        groups;
  logic signed [group_total-1:0] extended;
  logic [leb_len_width-1:0]      count;
  logic                          found;
  int                            shift;

  // First immediate byte sits in the top of the bus
  always_comb begin
    groups = '0;
    count  = leb_len_width'(leb_max_bytes);
    found  = 1'b0;
    for (int i = 0; i < leb_max_bytes; i++) begin
      if (!found) begin
        groups[leb_group_bits*i +: leb_group_bits] =
          bytes[8*(leb_max_bytes-1-i) +: leb_group_bits];
        // Clear continuation bit ends the number
        if (!bytes[8*(leb_max_bytes-1-i) + 7]) begin
          found = 1'b1;
          count = leb_len_width'(i + 1);
        end
      end
    end
  end

  // Move the last group's bit 6 to the MSB, then shift back arithmetically
  always_comb begin
    shift    = group_total - leb_group_bits * int'(count);
    extended = $signed(groups << shift) >>> shift;
  end

  assign value  = extended[63:0];
  assign length = count;

endmodule

`default_nettype wire

//--- verilog/operand_stack.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stack (
  input  logic                                   clk,
  input  logic                                   reset,
  input  wasm_machine_pkg::stack_op_t            op,
  input  logic [wasm_machine_pkg::entry_width-1:0] data,
  output logic [wasm_machine_pkg::entry_width-1:0] tos,
  output wasm_machine_pkg::stack_status_t        status
);

  import wasm_machine_pkg::*;

  localparam logic [stack_ptr_width-1:0] full_ptr = stack_ptr_width'(stack_depth);

  logic [entry_width-1:0]     entries [stack_depth];
  logic [stack_ptr_width-1:0] ptr;
  logic [stack_ptr_width-1:0] below;
  stack_status_t              error;

  // Index of the current top entry
  assign below = ptr - 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr   <= '0;
      error <= status_ok;
    end else begin
      case (op)
        stack_push: begin
          if (ptr == full_ptr) begin
            error <= status_overflow;
          end else begin
            ptr <= ptr + 1'b1;
          end
        end
        stack_pop: begin
          if (ptr == '0) begin
            error <= status_underflow;
          end else begin
            ptr <= below;
          end
        end
        stack_replace: begin
          if (ptr == '0) begin
            error <= status_underflow;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Contents stay untouched on a faulting op
  always_ff @(posedge clk) begin
    if (op == stack_push && ptr != full_ptr) begin
      entries[ptr[stack_idx_width-1:0]] <= data;
    end
    if (op == stack_replace && ptr != '0) begin
      entries[below[stack_idx_width-1:0]] <= data;
    end
  end

  assign tos = (ptr == '0) ? '0 : entries[below[stack_idx_width-1:0]];

  always_comb begin
    if (error != status_ok) begin
      status = error;
    end else if (ptr == '0) begin
      status = status_empty;
    end else begin
      status = status_ok;
    end
  end

  ptr_in_range: assert property (@(posedge clk) disable iff (reset) ptr <= full_ptr);

endmodule

`default_nettype wire

//--- verilog/code_mem.sv
`timescale 1ns/1ps
`default_nettype none

module code_mem #(
  parameter int addr_width = 6
) (
  input  logic                                      clk,
  input  logic                                      write,
  input  logic [addr_width-1:0]                     write_addr,
  input  byte                                       write_data,
  input  logic [addr_width-1:0]                     fetch_addr,
  output logic [wasm_machine_pkg::window_bytes*8-1:0] window,
  output logic                                      fetch_error
);

  import wasm_machine_pkg::*;

  localparam int mem_bytes = 2 ** addr_width;

  logic [7:0] mem [mem_bytes];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[write_addr] <= write_data;
    end
  end

  // Opcode lands in the top byte, later bytes toward the bottom
  always_ff @(posedge clk) begin
    for (int i = 0; i < window_bytes; i++) begin
      if (int'(fetch_addr) + i < mem_bytes) begin
        window[8*(window_bytes-1-i) +: 8] <= mem[int'(fetch_addr) + i];
      end else begin
        window[8*(window_bytes-1-i) +: 8] <= 8'h00;
      end
    end
    // Whole window must fit, even if the instruction is shorter
    fetch_error <= (int'(fetch_addr) + window_bytes - 1) > (mem_bytes - 1);
  end

  write_in_range: assert property (
    @(posedge clk) write |-> !$isunknown(write_addr) && (int'(write_addr) < mem_bytes)
  );

endmodule

`default_nettype wire

//--- verilog/wasm_machine_pkg.sv
`default_nettype none

package wasm_machine_pkg;

  typedef enum logic [2:0] {
    trap_none         = 3'd0,
    trap_stack        = 3'd1,
    trap_fetch        = 3'd2,
    trap_unreachable  = 3'd3,
    trap_type         = 3'd4,
    trap_unknown      = 3'd5,
    trap_select_types = 3'd6
  } trap_t;

  typedef enum logic [1:0] {
    stack_none    = 2'd0,
    stack_push    = 2'd1,
    stack_pop     = 2'd2,
    stack_replace = 2'd3
  } stack_op_t;

  typedef enum logic [1:0] {
    status_ok        = 2'd0,
    status_empty     = 2'd1,
    status_overflow  = 2'd2,
    status_underflow = 2'd3
  } stack_status_t;

  // Tag plus 64-bit payload
  localparam int entry_width     = 66;
  localparam int stack_depth     = 8;
  localparam int stack_idx_width = $clog2(stack_depth);
  localparam int stack_ptr_width = $clog2(stack_depth + 1);

  // Opcode byte followed by ten immediate bytes
  localparam int window_bytes = 11;

endpackage

`default_nettype wire

//--- verilog/wasm_isa_pkg.sv
`default_nettype none

package wasm_isa_pkg;

  // Control
  localparam logic [7:0] op_unreachable = 8'h00;
  localparam logic [7:0] op_nop         = 8'h01;
  localparam logic [7:0] op_end         = 8'h0b;
  localparam logic [7:0] op_call        = 8'h10;

  // Parametric
  localparam logic [7:0] op_drop   = 8'h1a;
  localparam logic [7:0] op_select = 8'h1b;

  // Constants
  localparam logic [7:0] op_i32_const = 8'h41;
  localparam logic [7:0] op_i64_const = 8'h42;
  localparam logic [7:0] op_f32_const = 8'h43;
  localparam logic [7:0] op_f64_const = 8'h44;

  // Integer tests
  localparam logic [7:0] op_i32_eqz = 8'h45;
  localparam logic [7:0] op_i32_eq  = 8'h46;
  localparam logic [7:0] op_i32_ne  = 8'h47;
  localparam logic [7:0] op_i64_eqz = 8'h50;
  localparam logic [7:0] op_i64_eq  = 8'h51;
  localparam logic [7:0] op_i64_ne  = 8'h52;

  // Arithmetic
  localparam logic [7:0] op_i32_add = 8'h6a;
  localparam logic [7:0] op_i32_sub = 8'h6b;
  localparam logic [7:0] op_i64_add = 8'h7c;
  localparam logic [7:0] op_i64_sub = 8'h7d;

  localparam logic [7:0] op_i32_reinterpret_f32 = 8'hbc;

  // Value-type tag carried in the top two bits of each stack entry
  typedef enum logic [1:0] {
    val_i32 = 2'd0,
    val_i64 = 2'd1,
    val_f32 = 2'd2,
    val_f64 = 2'd3
  } val_type_t;

  // A 64-bit value needs at most ten 7-bit groups
  localparam int leb_max_bytes  = 10;
  localparam int leb_group_bits = 7;
  localparam int leb_len_width  = 4;

endpackage

`default_nettype wire
